//--- common/bus_pkg.sv
package bus_pkg;

	localparam logic [31:0] CLINT_BASE   = 32'h0200_0000;
	localparam logic [31:0] CLINT_LIMIT  = 32'h0200_ffff;
	localparam logic [15:0] MTIME_LO_OFS = 16'hbff8;
	localparam logic [15:0] MTIME_HI_OFS = 16'hbffc;
	localparam logic [1:0]  RESP_OKAY    = 2'b00;
	localparam logic [1:0]  RESP_DECERR  = 2'b11;
	localparam logic [2:0]  FETCH_SIZE   = 3'd2; // 4 bytes.
	localparam logic [1:0]  BURST_INCR   = 2'b01;

	typedef enum logic [1:0] {
		OWN_IDLE = 2'd0,
		OWN_IFU  = 2'd1,
		OWN_LSU  = 2'd2
	} owner_e;

	typedef enum logic {
		TGT_SOC   = 1'b0,
		TGT_CLINT = 1'b1
	} target_e;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} lite_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} lite_r_t;

	typedef struct packed {
		logic [31:0] addr;
	} lite_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} lite_w_t;

	// shared by AR and AW.
	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} mst_a_t;

	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
		logic        last;
	} mst_w_t;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
		logic        last;
		logic [3:0]  id;
	} mst_r_t;

endpackage

//--- xbar/xbar_arbiter.sv
`timescale 1ns/1ps

module xbar_arbiter (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            ifu_ar_valid,
	input  logic            lsu_ar_valid,
	input  logic            ifu_r_done,
	input  logic            lsu_r_done,
	output bus_pkg::owner_e owner
);
	import bus_pkg::*;

	owner_e owner_next;

	always_comb begin
		owner_next = owner;
		case (owner)
			OWN_IDLE: begin
				// fetch wins a tie.
				if (ifu_ar_valid) begin
					owner_next = OWN_IFU;
				end else if (lsu_ar_valid) begin
					owner_next = OWN_LSU;
				end
			end
			OWN_IFU: begin
				if (ifu_r_done) begin
					owner_next = OWN_IDLE;
				end
			end
			OWN_LSU: begin
				if (lsu_r_done) begin
					owner_next = OWN_IDLE;
				end
			end
			default: owner_next = OWN_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			owner <= OWN_IDLE;
		end else begin
			owner <= owner_next;
		end
	end

endmodule

//--- xbar/xbar_read_route.sv
`timescale 1ns/1ps

module xbar_read_route (
	input  logic              clock,
	input  logic              rst_n,
	input  bus_pkg::owner_e   owner,
	input  bus_pkg::lite_ar_t ifu_ar,
	input  logic              ifu_ar_valid,
	output logic              ifu_ar_ready,
	output bus_pkg::lite_r_t  ifu_r,
	output logic              ifu_r_valid,
	input  logic              ifu_r_ready,
	input  bus_pkg::lite_ar_t lsu_ar,
	input  logic              lsu_ar_valid,
	output logic              lsu_ar_ready,
	output bus_pkg::lite_r_t  lsu_r,
	output logic              lsu_r_valid,
	input  logic              lsu_r_ready,
	output bus_pkg::mst_a_t   mst_ar,
	output logic              mst_ar_valid,
	input  logic              mst_ar_ready,
	input  bus_pkg::mst_r_t   mst_r,
	input  logic              mst_r_valid,
	output logic              mst_r_ready,
	output bus_pkg::lite_ar_t clint_ar,
	output logic              clint_ar_valid,
	input  logic              clint_ar_ready,
	input  bus_pkg::lite_r_t  clint_r,
	input  logic              clint_r_valid,
	output logic              clint_r_ready
);
	import bus_pkg::*;

	target_e  tgt_dec;
	target_e  tgt_q;
	lite_ar_t req;
	lite_r_t  r_sel;
	logic     ifu_own, lsu_own;
	logic     sent_q, lane_q;
	logic     req_valid, ar_ready, ar_fire;
	logic     r_valid, r_ready, r_fire;

	assign ifu_own = (owner == OWN_IFU);
	assign lsu_own = (owner == OWN_LSU);

	always_comb begin
		req = lsu_own ? lsu_ar : ifu_ar;
		tgt_dec = TGT_SOC; // fetches always go to the soc.
		if (lsu_own && lsu_ar.addr >= CLINT_BASE && lsu_ar.addr <= CLINT_LIMIT) begin
			tgt_dec = TGT_CLINT;
		end
	end

	// one request per ownership.
	assign req_valid = ~sent_q & (ifu_own & ifu_ar_valid | lsu_own & lsu_ar_valid);
	assign ar_ready = (tgt_dec == TGT_CLINT) ? clint_ar_ready : mst_ar_ready;
	assign ar_fire = req_valid & ar_ready;

	assign ifu_ar_ready = ifu_own & ~sent_q & ar_ready;
	assign lsu_ar_ready = lsu_own & ~sent_q & ar_ready;
	assign mst_ar_valid = req_valid & (tgt_dec == TGT_SOC);
	assign clint_ar_valid = req_valid & (tgt_dec == TGT_CLINT);
	assign clint_ar = lsu_ar;

	always_comb begin
		mst_ar.addr = req.addr;
		mst_ar.id = '0;
		mst_ar.len = '0;
		mst_ar.size = ifu_own ? FETCH_SIZE : lsu_ar.size;
		mst_ar.burst = BURST_INCR;
	end

	always_comb begin
		if (tgt_q == TGT_CLINT) begin
			r_sel = clint_r;
		end else begin
			r_sel.data = lane_q ? mst_r.data[63:32] : mst_r.data[31:0];
			r_sel.resp = mst_r.resp;
		end
	end

	assign r_valid = sent_q & ((tgt_q == TGT_CLINT) ? clint_r_valid : mst_r_valid);
	assign r_ready = ifu_own & ifu_r_ready | lsu_own & lsu_r_ready;
	assign r_fire = r_valid & r_ready;

	assign ifu_r = r_sel;
	assign lsu_r = r_sel;
	assign ifu_r_valid = ifu_own & r_valid;
	assign lsu_r_valid = lsu_own & r_valid;
	assign mst_r_ready = sent_q & (tgt_q == TGT_SOC) & r_ready;
	assign clint_r_ready = sent_q & (tgt_q == TGT_CLINT) & r_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			sent_q <= 1'b0;
			tgt_q <= TGT_SOC;
		end else if (ar_fire) begin
			sent_q <= 1'b1;
			tgt_q <= tgt_dec;
		end else if (r_fire) begin
			sent_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			lane_q <= req.addr[2]; // upper word of the beat.
		end
	end

endmodule

//--- xbar/xbar_write_path.sv
`timescale 1ns/1ps

module xbar_write_path (
	input  logic              clock,
	input  logic              rst_n,
	input  bus_pkg::lite_aw_t lsu_aw,
	input  logic              lsu_aw_valid,
	output logic              lsu_aw_ready,
	input  bus_pkg::lite_w_t  lsu_w,
	input  logic              lsu_w_valid,
	output logic              lsu_w_ready,
	output logic [1:0]        lsu_b_resp,
	output logic              lsu_b_valid,
	input  logic              lsu_b_ready,
	output bus_pkg::mst_a_t   mst_aw,
	output logic              mst_aw_valid,
	input  logic              mst_aw_ready,
	output bus_pkg::mst_w_t   mst_w,
	output logic              mst_w_valid,
	input  logic              mst_w_ready,
	input  logic [1:0]        mst_b_resp,
	input  logic              mst_b_valid,
	output logic              mst_b_ready
);
	import bus_pkg::*;

	logic aw_fire, w_fire;
	logic aw_done_q, lane_q, lane;

	assign aw_fire = lsu_aw_valid & mst_aw_ready;
	assign w_fire = lsu_w_valid & mst_w_ready;

	// W after its AW takes the stored lane.
	assign lane = aw_done_q ? lane_q : lsu_aw.addr[2];

	assign mst_aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = mst_aw_ready;
	assign mst_w_valid = lsu_w_valid;
	assign lsu_w_ready = mst_w_ready;

	always_comb begin
		mst_aw.addr = lsu_aw.addr;
		mst_aw.id = '0;
		mst_aw.len = '0;
		mst_aw.size = FETCH_SIZE; // one word per beat.
		mst_aw.burst = BURST_INCR;
		mst_w.data = lane ? {lsu_w.data, 32'h0} : {32'h0, lsu_w.data};
		mst_w.strb = lane ? {lsu_w.strb, 4'h0} : {4'h0, lsu_w.strb};
		mst_w.last = lsu_w_valid;
	end

	assign lsu_b_resp = mst_b_resp;
	assign lsu_b_valid = mst_b_valid;
	assign mst_b_ready = lsu_b_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			aw_done_q <= 1'b0;
		end else if (aw_fire && !w_fire) begin
			aw_done_q <= 1'b1;
		end else if (w_fire) begin
			aw_done_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			lane_q <= lsu_aw.addr[2];
		end
	end

endmodule

//--- xbar/xbar.sv
`timescale 1ns/1ps

module xbar (
	input  logic              clock,
	input  logic              rst_n,
	input  bus_pkg::lite_ar_t ifu_ar,
	input  logic              ifu_ar_valid,
	output logic              ifu_ar_ready,
	output bus_pkg::lite_r_t  ifu_r,
	output logic              ifu_r_valid,
	input  logic              ifu_r_ready,
	input  bus_pkg::lite_ar_t lsu_ar,
	input  logic              lsu_ar_valid,
	output logic              lsu_ar_ready,
	output bus_pkg::lite_r_t  lsu_r,
	output logic              lsu_r_valid,
	input  logic              lsu_r_ready,
	input  bus_pkg::lite_aw_t lsu_aw,
	input  logic              lsu_aw_valid,
	output logic              lsu_aw_ready,
	input  bus_pkg::lite_w_t  lsu_w,
	input  logic              lsu_w_valid,
	output logic              lsu_w_ready,
	output logic [1:0]        lsu_b_resp,
	output logic              lsu_b_valid,
	input  logic              lsu_b_ready,
	output bus_pkg::mst_a_t   mst_ar,
	output logic              mst_ar_valid,
	input  logic              mst_ar_ready,
	input  bus_pkg::mst_r_t   mst_r,
	input  logic              mst_r_valid,
	output logic              mst_r_ready,
	output bus_pkg::mst_a_t   mst_aw,
	output logic              mst_aw_valid,
	input  logic              mst_aw_ready,
	output bus_pkg::mst_w_t   mst_w,
	output logic              mst_w_valid,
	input  logic              mst_w_ready,
	input  logic [1:0]        mst_b_resp,
	input  logic              mst_b_valid,
	output logic              mst_b_ready,
	output bus_pkg::lite_ar_t clint_ar,
	output logic              clint_ar_valid,
	input  logic              clint_ar_ready,
	input  bus_pkg::lite_r_t  clint_r,
	input  logic              clint_r_valid,
	output logic              clint_r_ready
);
	import bus_pkg::*;

	owner_e owner;
	logic   ifu_r_done, lsu_r_done;

	// ownership ends with the owner's R handshake.
	assign ifu_r_done = ifu_r_valid & ifu_r_ready;
	assign lsu_r_done = lsu_r_valid & lsu_r_ready;

	xbar_arbiter u_arbiter (.*);

	xbar_read_route u_read_route (.*);

	xbar_write_path u_write_path (.*);

endmodule

//--- logic/clint.sv
`timescale 1ns/1ps

module clint (
	input  logic              clock,
	input  logic              rst_n,
	input  bus_pkg::lite_ar_t ar,
	input  logic              ar_valid,
	output logic              ar_ready,
	output bus_pkg::lite_r_t  r,
	output logic              r_valid,
	input  logic              r_ready
);
	import bus_pkg::*;

	logic [63:0] mtime;
	logic        ar_fire;
	lite_r_t     r_next;

	assign ar_ready = ~r_valid; // one response held at a time.
	assign ar_fire = ar_valid & ar_ready;

	always_comb begin
		case (ar.addr[15:0])
			MTIME_LO_OFS: begin
				r_next.data = mtime[31:0];
				r_next.resp = RESP_OKAY;
			end
			MTIME_HI_OFS: begin
				r_next.data = mtime[63:32];
				r_next.resp = RESP_OKAY;
			end
			default: begin
				r_next.data = '0;
				r_next.resp = RESP_DECERR;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
			r_valid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1; // free running.
			if (ar_fire) begin
				r_valid <= 1'b1;
			end else if (r_ready) begin
				r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			r <= r_next;
		end
	end

endmodule

//--- logic/bus_fabric_top.sv
`timescale 1ns/1ps

module bus_fabric_top (
	input  logic              clock,
	input  logic              rst_n,
	input  bus_pkg::lite_ar_t ifu_ar,
	input  logic              ifu_ar_valid,
	output logic              ifu_ar_ready,
	output bus_pkg::lite_r_t  ifu_r,
	output logic              ifu_r_valid,
	input  logic              ifu_r_ready,
	input  bus_pkg::lite_ar_t lsu_ar,
	input  logic              lsu_ar_valid,
	output logic              lsu_ar_ready,
	output bus_pkg::lite_r_t  lsu_r,
	output logic              lsu_r_valid,
	input  logic              lsu_r_ready,
	input  bus_pkg::lite_aw_t lsu_aw,
	input  logic              lsu_aw_valid,
	output logic              lsu_aw_ready,
	input  bus_pkg::lite_w_t  lsu_w,
	input  logic              lsu_w_valid,
	output logic              lsu_w_ready,
	output logic [1:0]        lsu_b_resp,
	output logic              lsu_b_valid,
	input  logic              lsu_b_ready,
	output bus_pkg::mst_a_t   mst_ar,
	output logic              mst_ar_valid,
	input  logic              mst_ar_ready,
	input  bus_pkg::mst_r_t   mst_r,
	input  logic              mst_r_valid,
	output logic              mst_r_ready,
	output bus_pkg::mst_a_t   mst_aw,
	output logic              mst_aw_valid,
	input  logic              mst_aw_ready,
	output bus_pkg::mst_w_t   mst_w,
	output logic              mst_w_valid,
	input  logic              mst_w_ready,
	input  logic [1:0]        mst_b_resp,
	input  logic              mst_b_valid,
	output logic              mst_b_ready
);
	import bus_pkg::*;

	// core-local timer port.
	lite_ar_t clint_ar;
	lite_r_t  clint_r;
	logic     clint_ar_valid, clint_ar_ready;
	logic     clint_r_valid, clint_r_ready;

	xbar u_xbar (.*);

	clint u_clint (
		.clock    (clock),
		.rst_n    (rst_n),
		.ar       (clint_ar),
		.ar_valid (clint_ar_valid),
		.ar_ready (clint_ar_ready),
		.r        (clint_r),
		.r_valid  (clint_r_valid),
		.r_ready  (clint_r_ready)
	);

endmodule

//--- verif/soc_mem_model.sv
`timescale 1ns/1ps

module soc_mem_model (
	input  logic            clock,
	input  logic            rst_n,
	input  bus_pkg::mst_a_t ar,
	input  logic            ar_valid,
	output logic            ar_ready,
	output bus_pkg::mst_r_t r,
	output logic            r_valid,
	input  logic            r_ready,
	input  bus_pkg::mst_a_t aw,
	input  logic            aw_valid,
	output logic            aw_ready,
	input  bus_pkg::mst_w_t w,
	input  logic            w_valid,
	output logic            w_ready,
	output logic [1:0]      b_resp,
	output logic            b_valid,
	input  logic            b_ready
);
	import bus_pkg::*;

	logic [31:0] mem_data [64];
	logic [3:0]  mem_mask [64]; // bytes written since the tag was set.
	logic [29:0] mem_tag [64];
	logic        rd_busy, aw_got, w_got, wr_go;
	logic [1:0]  rd_cnt;
	logic [31:0] rd_addr, aw_addr_q, wr_addr, wr_data;
	logic [3:0]  wr_strb;
	mst_w_t      w_q, wr_beat;

	// stored bytes laid over the address pattern.
	function automatic logic [31:0] word_value(input logic [31:0] addr);
		logic [31:0] val;
		logic [5:0]  idx;
		idx = addr[7:2];
		val = {addr[31:2], 2'b00} ^ 32'ha5a5_0000;
		if (mem_tag[idx] == addr[31:2]) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_mask[idx][i]) begin
					val[8*i +: 8] = mem_data[idx][8*i +: 8];
				end
			end
		end
		return val;
	endfunction

	assign ar_ready = ~rd_busy;
	assign aw_ready = ~aw_got & ~b_valid;
	assign w_ready = ~w_got & ~b_valid;
	assign b_resp = RESP_OKAY;
	assign wr_addr = aw_got ? aw_addr_q : aw.addr;
	assign wr_beat = w_got ? w_q : w;
	assign wr_data = wr_addr[2] ? wr_beat.data[63:32] : wr_beat.data[31:0];
	assign wr_strb = wr_addr[2] ? wr_beat.strb[7:4] : wr_beat.strb[3:0];
	assign wr_go = (aw_got | aw_valid & aw_ready) & (w_got | w_valid & w_ready) & ~b_valid;

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			rd_cnt <= 2'd0;
			r_valid <= 1'b0;
			r <= '0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			b_valid <= 1'b0;
			for (int i = 0; i < 64; i++) begin
				mem_mask[i] <= '0;
				mem_tag[i] <= '0;
			end
		end else begin
			if (ar_valid && ar_ready) begin
				rd_busy <= 1'b1;
				rd_addr <= ar.addr;
				rd_cnt <= 2'd1;
			end else if (rd_busy && !r_valid) begin
				if (rd_cnt == 2'd0) begin
					r_valid <= 1'b1; // two cycles after the AR handshake.
					r.data <= {word_value({rd_addr[31:3], 3'b100}),
						word_value({rd_addr[31:3], 3'b000})};
					r.resp <= RESP_OKAY;
					r.last <= 1'b1;
					r.id <= '0;
				end else begin
					rd_cnt <= rd_cnt - 2'd1;
				end
			end else if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_busy <= 1'b0;
			end
			if (aw_valid && aw_ready) begin
				aw_got <= 1'b1;
				aw_addr_q <= aw.addr;
			end
			if (w_valid && w_ready) begin
				w_got <= 1'b1;
				w_q <= w;
			end
			if (wr_go) begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
				b_valid <= 1'b1;
				for (int i = 0; i < 4; i++) begin
					if (wr_strb[i]) begin
						mem_data[wr_addr[7:2]][8*i +: 8] <= wr_data[8*i +: 8];
					end
				end
				mem_tag[wr_addr[7:2]] <= wr_addr[31:2];
				mem_mask[wr_addr[7:2]] <= wr_strb |
					((mem_tag[wr_addr[7:2]] == wr_addr[31:2]) ? mem_mask[wr_addr[7:2]] : 4'h0);
			end else if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end
		end
	end

endmodule

//--- verif/bus_fabric_tb.sv
`timescale 1ns/1ps

module bus_fabric_tb;
	import bus_pkg::*;

	// about 60 transactions of at most 20 cycles, doubled, plus reset.
	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [31:0] RAM_BASE = 32'h8000_1000;

	logic        clock, rst_n;
	lite_ar_t    ifu_ar, lsu_ar;
	lite_r_t     ifu_r, lsu_r;
	logic        ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
	logic        lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
	lite_aw_t    lsu_aw;
	lite_w_t     lsu_w;
	logic        lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
	logic [1:0]  lsu_b_resp, mst_b_resp;
	logic        lsu_b_valid, lsu_b_ready, mst_b_valid, mst_b_ready;
	mst_a_t      mst_ar, mst_aw;
	mst_r_t      mst_r;
	mst_w_t      mst_w;
	logic        mst_ar_valid, mst_ar_ready, mst_r_valid, mst_r_ready;
	logic        mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
	int          cycles;
	int          ticks; // counts like mtime from reset release.
	logic [31:0] lfsr;
	logic [31:0] shadow_data [logic [31:0]];
	logic [3:0]  shadow_mask [logic [31:0]];

	bus_fabric_top dut (.*);

	soc_mem_model u_soc (
		.clock    (clock),
		.rst_n    (rst_n),
		.ar       (mst_ar),
		.ar_valid (mst_ar_valid),
		.ar_ready (mst_ar_ready),
		.r        (mst_r),
		.r_valid  (mst_r_valid),
		.r_ready  (mst_r_ready),
		.aw       (mst_aw),
		.aw_valid (mst_aw_valid),
		.aw_ready (mst_aw_ready),
		.w        (mst_w),
		.w_valid  (mst_w_valid),
		.w_ready  (mst_w_ready),
		.b_resp   (mst_b_resp),
		.b_valid  (mst_b_valid),
		.b_ready  (mst_b_ready)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (rst_n) begin
			ticks <= ticks + 1;
		end
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: run still busy after %0d cycles", cycles));
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_lite_r(input string name, input lite_r_t got, input lite_r_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
		end
	endtask

	task automatic check_mst_a(input string name, input mst_a_t got, input mst_a_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
		end
	endtask

	task automatic check_mst_w(input string name, input mst_w_t got, input mst_w_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
		end
	endtask

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// address pattern with any written bytes merged in.
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] word, val, stored;
		logic [3:0]  mask;
		word = {addr[31:2], 2'b00};
		val = word ^ 32'ha5a5_0000;
		if (shadow_mask.exists(word)) begin
			stored = shadow_data[word];
			mask = shadow_mask[word];
			for (int i = 0; i < 4; i++) begin
				if (mask[i]) begin
					val[8*i +: 8] = stored[8*i +: 8];
				end
			end
		end
		return val;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic do_read(input bit lsu, input logic [31:0] addr, input logic [2:0] size,
			input int hold, output lite_r_t got, output mst_a_t beat, output bit saw_mst,
			output int stamp);
		lite_r_t first;
		saw_mst = 1'b0;
		if (lsu) begin
			lsu_ar = '{addr, size};
			lsu_ar_valid = 1'b1;
		end else begin
			ifu_ar = '{addr, size};
			ifu_ar_valid = 1'b1;
		end
		do begin
			@(negedge clock);
			saw_mst = saw_mst | mst_ar_valid;
		end while (!(lsu ? lsu_ar_ready : ifu_ar_ready));
		beat = mst_ar;
		stamp = ticks; // mtime sampled at this handshake.
		next_cycle();
		lsu_ar_valid = 1'b0;
		ifu_ar_valid = 1'b0;
		do begin
			@(negedge clock);
			saw_mst = saw_mst | mst_ar_valid;
		end while (!(lsu ? lsu_r_valid : ifu_r_valid));
		first = lsu ? lsu_r : ifu_r;
		for (int i = 0; i < hold; i++) begin
			@(negedge clock);
			if (!(lsu ? lsu_r_valid : ifu_r_valid)) begin
				abort_run("rvalid dropped before the response was accepted");
			end
			check_lite_r("r_held", lsu ? lsu_r : ifu_r, first);
		end
		next_cycle();
		lsu_r_ready = lsu;
		ifu_r_ready = ~lsu;
		@(negedge clock);
		check_lite_r("r_held", lsu ? lsu_r : ifu_r, first);
		got = first;
		next_cycle();
		lsu_r_ready = 1'b0;
		ifu_r_ready = 1'b0;
	endtask

	task automatic test_fetch(input logic [31:0] addr, input int hold);
		lite_r_t got, exp_r;
		mst_a_t  beat, exp_a;
		bit      saw;
		int      stamp;
		do_read(1'b0, addr, FETCH_SIZE, hold, got, beat, saw, stamp);
		exp_a = '{addr, 4'd0, 8'd0, FETCH_SIZE, BURST_INCR};
		exp_r = '{expected_word(addr), RESP_OKAY};
		check_mst_a("mst_ar", beat, exp_a);
		check_lite_r("ifu_r", got, exp_r);
	endtask

	task automatic test_lsu_read(input logic [31:0] addr, input logic [2:0] size, input int hold);
		lite_r_t got, exp_r;
		mst_a_t  beat, exp_a;
		bit      saw;
		int      stamp;
		do_read(1'b1, addr, size, hold, got, beat, saw, stamp);
		exp_a = '{addr, 4'd0, 8'd0, size, BURST_INCR};
		exp_r = '{expected_word(addr), RESP_OKAY};
		check_mst_a("mst_ar", beat, exp_a);
		check_lite_r("lsu_r", got, exp_r);
	endtask

	task automatic test_clint_read(input logic [15:0] ofs, input int hold,
			output logic [31:0] data);
		lite_r_t got, exp_r;
		mst_a_t  beat;
		bit      saw;
		int      stamp;
		do_read(1'b1, CLINT_BASE | {16'h0, ofs}, 3'd2, hold, got, beat, saw, stamp);
		if (saw) begin
			abort_run("master arvalid went high during a CLINT read");
		end
		if (ofs == MTIME_LO_OFS) begin
			exp_r = '{stamp, RESP_OKAY};
		end else if (ofs == MTIME_HI_OFS) begin
			exp_r = '{32'h0, RESP_OKAY}; // mtime stays below 2^32 here.
		end else begin
			exp_r = '{32'h0, RESP_DECERR};
		end
		check_lite_r("lsu_r", got, exp_r);
		data = got.data;
	endtask

	task automatic test_tie(input logic [31:0] ifu_addr, input logic [31:0] lsu_addr);
		bit      ifu_done, lsu_done, ifu_ar_hs, lsu_ar_hs, ifu_r_hs, lsu_r_hs;
		lite_r_t exp_i, exp_l;
		exp_i = '{expected_word(ifu_addr), RESP_OKAY};
		exp_l = '{expected_word(lsu_addr), RESP_OKAY};
		ifu_ar = '{ifu_addr, FETCH_SIZE};
		lsu_ar = '{lsu_addr, 3'd2};
		ifu_ar_valid = 1'b1;
		lsu_ar_valid = 1'b1;
		ifu_r_ready = 1'b1;
		lsu_r_ready = 1'b1;
		ifu_done = 1'b0;
		lsu_done = 1'b0;
		while (!lsu_done) begin
			@(negedge clock);
			if (!ifu_done && (lsu_ar_ready || lsu_r_valid)) begin
				abort_run("lsu was served before the fetch completed");
			end
			if (ifu_done && ifu_r_valid) begin
				abort_run("ifu saw a response that belongs to the lsu");
			end
			ifu_ar_hs = ifu_ar_valid & ifu_ar_ready;
			lsu_ar_hs = lsu_ar_valid & lsu_ar_ready;
			ifu_r_hs = ifu_r_valid & ifu_r_ready;
			lsu_r_hs = lsu_r_valid & lsu_r_ready;
			if (ifu_r_hs) begin
				check_lite_r("ifu_r", ifu_r, exp_i);
				ifu_done = 1'b1;
			end
			if (lsu_r_hs) begin
				check_lite_r("lsu_r", lsu_r, exp_l);
				lsu_done = 1'b1;
			end
			next_cycle();
			if (ifu_ar_hs) begin
				ifu_ar_valid = 1'b0;
			end
			if (lsu_ar_hs) begin
				lsu_ar_valid = 1'b0;
			end
			if (ifu_r_hs) begin
				ifu_r_ready = 1'b0;
			end
		end
		lsu_r_ready = 1'b0;
	endtask

	task automatic test_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		bit          aw_hs, w_hs, b_done;
		mst_a_t      exp_a;
		mst_w_t      exp_w;
		logic [31:0] word, stored;
		exp_a = '{addr, 4'd0, 8'd0, FETCH_SIZE, BURST_INCR};
		exp_w.data = addr[2] ? {data, 32'h0} : {32'h0, data}; // lane by address bit 2.
		exp_w.strb = addr[2] ? {strb, 4'h0} : {4'h0, strb};
		exp_w.last = 1'b1;
		lsu_aw.addr = addr;
		lsu_w = '{data, strb};
		lsu_aw_valid = 1'b1;
		lsu_w_valid = 1'b1;
		lsu_b_ready = 1'b1;
		b_done = 1'b0;
		while (!b_done) begin
			@(negedge clock);
			aw_hs = lsu_aw_valid & lsu_aw_ready;
			w_hs = lsu_w_valid & lsu_w_ready;
			if (aw_hs) begin
				check_mst_a("mst_aw", mst_aw, exp_a);
			end
			if (w_hs) begin
				check_mst_w("mst_w", mst_w, exp_w);
			end
			if (lsu_b_valid) begin
				check_resp("lsu_b_resp", lsu_b_resp, RESP_OKAY);
				b_done = 1'b1;
			end
			next_cycle();
			if (aw_hs) begin
				lsu_aw_valid = 1'b0;
			end
			if (w_hs) begin
				lsu_w_valid = 1'b0;
			end
		end
		lsu_b_ready = 1'b0;
		word = {addr[31:2], 2'b00};
		if (!shadow_mask.exists(word)) begin
			shadow_mask[word] = 4'h0;
			shadow_data[word] = 32'h0;
		end
		stored = shadow_data[word];
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				stored[8*i +: 8] = data[8*i +: 8];
			end
		end
		shadow_data[word] = stored;
		shadow_mask[word] = shadow_mask[word] | strb;
	endtask

	task automatic test_random(input int count);
		logic [31:0] kind, hold, bits, addr, data, sz;
		for (int n = 0; n < count; n++) begin
			take_bits(2, kind);
			take_bits(2, hold); // rready low for 0 to 3 cycles.
			take_bits(6, bits);
			addr = RAM_BASE | {24'h0, bits[5:0], 2'b00};
			case (kind[1:0])
				2'd0: test_fetch(addr, hold);
				2'd1: begin
					take_bits(2, sz);
					if (sz == 32'd3) begin
						sz = 32'd2;
					end
					take_bits(2, bits);
					addr[1:0] = (sz == 32'd0) ? bits[1:0] : (sz == 32'd1) ? {bits[1], 1'b0} : 2'b00;
					test_lsu_read(addr, sz[2:0], hold);
				end
				2'd2: begin
					take_bits(2, bits);
					if (bits[1:0] == 2'd0) begin
						test_clint_read(MTIME_HI_OFS, hold, data);
					end else if (bits[1:0] == 2'd1) begin
						test_clint_read(16'h0000, hold, data);
					end else begin
						test_clint_read(MTIME_LO_OFS, hold, data);
					end
				end
				default: begin
					take_bits(32, data);
					take_bits(4, bits);
					test_write(addr, data, bits[3:0]);
				end
			endcase
		end
	endtask

	initial begin
		logic [31:0] t0, t1;
		cycles = 0;
		ticks = 0;
		lfsr = 32'h7d08;
		rst_n = 1'b0;
		ifu_ar = '0;
		ifu_ar_valid = 1'b0;
		ifu_r_ready = 1'b0;
		lsu_ar = '0;
		lsu_ar_valid = 1'b0;
		lsu_r_ready = 1'b0;
		lsu_aw = '0;
		lsu_aw_valid = 1'b0;
		lsu_w = '0;
		lsu_w_valid = 1'b0;
		lsu_b_ready = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		rst_n = 1'b1;
		next_cycle();
		test_fetch(32'h0000_2000, 0);
		test_fetch(32'h0000_2004, 1);
		test_lsu_read(32'h8000_0203, 3'd0, 0);
		test_lsu_read(32'h8000_0206, 3'd1, 1);
		test_lsu_read(32'h8000_0208, 3'd2, 2);
		test_clint_read(MTIME_LO_OFS, 0, t0);
		test_clint_read(MTIME_LO_OFS, 1, t1);
		if (t1 <= t0) begin
			abort_run("mtime did not increase between two reads");
		end
		test_clint_read(MTIME_HI_OFS, 0, t0);
		test_clint_read(16'h0000, 2, t0);
		test_tie(32'h0000_3004, 32'h8000_0310);
		test_write(RAM_BASE + 32'h20, 32'h1122_3344, 4'b0101);
		test_write(RAM_BASE + 32'h24, 32'hdead_beef, 4'b1110);
		test_lsu_read(RAM_BASE + 32'h20, 3'd2, 0);
		test_lsu_read(RAM_BASE + 32'h24, 3'd2, 1);
		test_random(40);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- bus_fabric_top.f
common/bus_pkg.sv
xbar/xbar_arbiter.sv
xbar/xbar_read_route.sv
xbar/xbar_write_path.sv
xbar/xbar.sv
logic/clint.sv
logic/bus_fabric_top.sv
verif/soc_mem_model.sv
verif/bus_fabric_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module bus_fabric_tb \
	-f bus_fabric_top.f -o bus_fabric_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/bus_fabric_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1
